// ==== dft2d_pkg.sv ====
`default_nettype none

package dft2d_pkg;

  localparam int TILE_N       = 4;                // tile edge and dft length
  localparam int TILE_SAMPLES = TILE_N * TILE_N;  // samples per tile
  localparam int IN_W         = 12;               // real input sample
  localparam int ROW_W        = 14;               // after row pass, 4x growth
  localparam int OUT_W        = 16;               // after column pass, 16x growth

  typedef logic signed [IN_W-1:0] in_sample_t;

  typedef struct packed {
    logic signed [ROW_W-1:0] re;
    logic signed [ROW_W-1:0] im;
  } row_cplx_t;

  typedef struct packed {
    logic signed [OUT_W-1:0] re;
    logic signed [OUT_W-1:0] im;
  } out_cplx_t;

  typedef logic [1:0] idx_t;  // position within a row or column

  // real sample into a complex row element, imag tied to zero
  function automatic row_cplx_t to_row(input in_sample_t s);
    row_cplx_t r;
    r.re = ROW_W'(s);  // sign extend
    r.im = '0;
    return r;
  endfunction

  function automatic out_cplx_t to_out(input row_cplx_t x);
    out_cplx_t r;
    r.re = OUT_W'(x.re);  // sign extend
    r.im = OUT_W'(x.im);
    return r;
  endfunction

  // -j * (re + j im) = im - j re
  function automatic out_cplx_t mul_neg_j(input out_cplx_t x);
    out_cplx_t r;
    r.re = x.im;
    r.im = -x.re;
    return r;
  endfunction

endpackage

`default_nettype wire

// ==== cplx_vec_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface cplx_vec_if import dft2d_pkg::*; #(
  parameter type elem_t = row_cplx_t  // element of the vector
);

  logic  valid;           // vector present
  logic  ready;           // sink can take it
  elem_t data [TILE_N];   // one row or one column
  logic  last;            // final vector of a tile

  // source holds data, last and valid until valid && ready
  modport src (
    output valid,
    output data,
    output last,
    input  ready
  );

  modport snk (
    input  valid,
    input  data,
    input  last,
    output ready
  );

endinterface

`default_nettype wire

// ==== row_gather.sv ====
`timescale 1ns/1ps
`default_nettype none

module row_gather import dft2d_pkg::*; (
  input  logic       clk,
  input  logic       rst_n_i,
  input  in_sample_t sample_i,
  input  logic       sample_valid_i,
  output logic       sample_ready_o,
  cplx_vec_if.src    row_o
);

  in_sample_t shift_q [TILE_N];  // row being collected, oldest at 0
  idx_t       col_q;             // next column position
  idx_t       row_q;             // row within tile of the waiting vector
  logic       full_q;            // completed row waits for the row dft
  logic       accept;
  logic       row_take;

  assign sample_ready_o = ~full_q;  // stall input while a row waits
  assign accept         = sample_valid_i & sample_ready_o;
  assign row_take       = row_o.valid & row_o.ready;

  assign row_o.valid = full_q;
  assign row_o.last  = (row_q == idx_t'(TILE_N - 1));  // fourth row closes the tile

  always_comb
  begin
    for (int k = 0; k < TILE_N; k++)
    begin
      row_o.data[k] = to_row(shift_q[k]);  // real in, imag zero
    end
  end

  // sample shift register, newest enters at the top
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      for (int k = 0; k < TILE_N - 1; k++)
      begin
        shift_q[k] <= shift_q[k+1];
      end
      shift_q[TILE_N-1] <= sample_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      col_q  <= '0;
      row_q  <= '0;
      full_q <= 1'b0;
    end
    else
    begin
      if (accept)
      begin
        col_q <= col_q + 1'b1;  // wraps to 0 after column 3
        if (col_q == idx_t'(TILE_N - 1))
        begin
          full_q <= 1'b1;  // vector valid next cycle
        end
      end
      else if (row_take)
      begin
        full_q <= 1'b0;
        row_q  <= row_q + 1'b1;  // wraps at tile end
      end
    end
  end

endmodule

`default_nettype wire

// ==== dft4_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module dft4_unit import dft2d_pkg::*; #(
  parameter type in_t  = row_cplx_t,  // element type on vec_i
  parameter type out_t = row_cplx_t   // element type on vec_o
) (
  input  logic    clk,
  input  logic    rst_n_i,
  cplx_vec_if.snk vec_i,
  cplx_vec_if.src vec_o
);

  localparam int OW = $bits(out_t) / 2;  // one component of out_t

  in_t       in_elem [TILE_N];
  out_cplx_t w       [TILE_N];  // inputs widened to full width
  out_cplx_t y       [TILE_N];  // full width results
  out_t      y_n     [TILE_N];  // results sized to out_t
  out_t      res_q   [TILE_N];  // output register
  out_cplx_t s02;
  out_cplx_t d02;
  out_cplx_t s13;
  out_cplx_t d13;
  out_cplx_t rot;               // -j * (b - d)
  logic      valid_q;
  logic      last_q;
  logic      take;

  assign vec_i.ready = ~valid_q | vec_o.ready;  // empty or draining this cycle
  assign take        = vec_i.valid & vec_i.ready;

  always_comb
  begin
    for (int k = 0; k < TILE_N; k++)
    begin
      in_elem[k] = vec_i.data[k];
      w[k]       = to_out(in_elem[k]);
    end
    s02.re = w[0].re + w[2].re;  // a + c
    s02.im = w[0].im + w[2].im;
    d02.re = w[0].re - w[2].re;  // a - c
    d02.im = w[0].im - w[2].im;
    s13.re = w[1].re + w[3].re;  // b + d
    s13.im = w[1].im + w[3].im;
    d13.re = w[1].re - w[3].re;  // b - d
    d13.im = w[1].im - w[3].im;
    rot    = mul_neg_j(d13);
    y[0].re = s02.re + s13.re;   // X0
    y[0].im = s02.im + s13.im;
    y[1].re = d02.re + rot.re;   // X1 = (a-c) - j(b-d)
    y[1].im = d02.im + rot.im;
    y[2].re = s02.re - s13.re;   // X2
    y[2].im = s02.im - s13.im;
    y[3].re = d02.re - rot.re;   // X3 = (a-c) + j(b-d)
    y[3].im = d02.im - rot.im;
    for (int k = 0; k < TILE_N; k++)
    begin
      y_n[k].re = y[k].re[OW-1:0];  // row pass fits in ROW_W
      y_n[k].im = y[k].im[OW-1:0];
    end
  end

  always_ff @(posedge clk)
  begin
    if (take)
    begin
      res_q <= y_n;
    end
  end

  always_ff @(posedge clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      valid_q <= 1'b0;
      last_q  <= 1'b0;
    end
    else if (take)
    begin
      valid_q <= 1'b1;  // result one cycle after input transfer
      last_q  <= vec_i.last;
    end
    else if (vec_o.ready)
    begin
      valid_q <= 1'b0;
    end
  end

  assign vec_o.valid = valid_q;
  assign vec_o.last  = last_q;
  assign vec_o.data  = res_q;

endmodule

`default_nettype wire

// ==== corner_turn_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module corner_turn_buffer import dft2d_pkg::*; (
  input  logic    clk,
  input  logic    rst_n_i,
  cplx_vec_if.snk row_i,
  cplx_vec_if.src col_o
);

  // flat tile store per bank, address is {row, col}
  row_cplx_t mem_q [2][TILE_SAMPLES];

  logic       wr_bank_q;  // bank being filled by rows
  idx_t       wr_row_q;   // next row to write
  logic       rd_bank_q;  // bank being drained by columns
  idx_t       rd_col_q;   // next column to present
  logic [1:0] full_q;     // bank holds a complete tile
  logic       wr_take;
  logic       rd_take;

  assign row_i.ready = ~full_q[wr_bank_q];  // both banks full stalls the writer
  assign wr_take     = row_i.valid & row_i.ready;

  assign col_o.valid = full_q[rd_bank_q];
  assign col_o.last  = (rd_col_q == idx_t'(TILE_N - 1));  // column 3 ends the tile
  assign rd_take     = col_o.valid & col_o.ready;

  // column read, stride TILE_N through the bank
  always_comb
  begin
    for (int k = 0; k < TILE_N; k++)
    begin
      col_o.data[k] = mem_q[rd_bank_q][{idx_t'(k), rd_col_q}];
    end
  end

  // whole row written in one transfer
  always_ff @(posedge clk)
  begin
    if (wr_take)
    begin
      for (int k = 0; k < TILE_N; k++)
      begin
        mem_q[wr_bank_q][{wr_row_q, idx_t'(k)}] <= row_i.data[k];
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      wr_bank_q <= 1'b0;
      wr_row_q  <= '0;
      rd_bank_q <= 1'b0;
      rd_col_q  <= '0;
      full_q    <= '0;
    end
    else
    begin
      if (wr_take)
      begin
        wr_row_q <= row_i.last ? idx_t'(0) : wr_row_q + 1'b1;
        if (row_i.last)
        begin
          full_q[wr_bank_q] <= 1'b1;  // readable next cycle
          wr_bank_q         <= ~wr_bank_q;
        end
      end
      // read and write banks always differ here
      if (rd_take)
      begin
        rd_col_q <= rd_col_q + 1'b1;  // wraps after column 3
        if (col_o.last)
        begin
          full_q[rd_bank_q] <= 1'b0;  // bank free for the writer
          rd_bank_q         <= ~rd_bank_q;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== out_serializer.sv ====
`timescale 1ns/1ps
`default_nettype none

module out_serializer import dft2d_pkg::*; (
  input  logic                    clk,
  input  logic                    rst_n_i,
  cplx_vec_if.snk                 col_i,
  output logic signed [OUT_W-1:0] out_re_o,
  output logic signed [OUT_W-1:0] out_im_o,
  output logic                    out_valid_o,
  input  logic                    out_ready_i,
  output logic                    out_last_o
);

  out_cplx_t vec_q [TILE_N];  // held column vector
  idx_t      elem_q;          // element on the output
  logic      valid_q;         // vector held
  logic      last_q;          // held vector is the tile's last column
  logic      out_take;
  logic      done;
  logic      take;

  assign out_take = valid_q & out_ready_i;
  assign done     = out_take & (elem_q == idx_t'(TILE_N - 1));  // last element leaves

  // reload in the cycle the last element goes out, no bubble
  assign col_i.ready = ~valid_q | done;
  assign take        = col_i.valid & col_i.ready;

  assign out_valid_o = valid_q;
  assign out_re_o    = vec_q[elem_q].re;
  assign out_im_o    = vec_q[elem_q].im;
  assign out_last_o  = last_q & (elem_q == idx_t'(TILE_N - 1));  // X[3][3]

  always_ff @(posedge clk)
  begin
    if (take)
    begin
      vec_q <= col_i.data;
    end
  end

  always_ff @(posedge clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      valid_q <= 1'b0;
      last_q  <= 1'b0;
      elem_q  <= '0;
    end
    else if (take)
    begin
      valid_q <= 1'b1;
      last_q  <= col_i.last;
      elem_q  <= '0;
    end
    else if (done)
    begin
      valid_q <= 1'b0;
      elem_q  <= '0;
    end
    else if (out_take)
    begin
      elem_q <= elem_q + 1'b1;  // next u of the same column
    end
  end

endmodule

`default_nettype wire

// ==== tile_dft2d_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tile_dft2d_top import dft2d_pkg::*; (
  input  logic                    clk,
  input  logic                    rst_n_i,
  input  in_sample_t              sample_i,        // row-major real samples
  input  logic                    sample_valid_i,
  output logic                    sample_ready_o,
  output logic signed [OUT_W-1:0] out_re_o,        // column-major X[u][v]
  output logic signed [OUT_W-1:0] out_im_o,
  output logic                    out_valid_o,
  input  logic                    out_ready_i,
  output logic                    out_last_o       // high on X[3][3]
);

  cplx_vec_if #(.elem_t(row_cplx_t)) raw_row  ();  // gathered rows, imag zero
  cplx_vec_if #(.elem_t(row_cplx_t)) row_spec ();  // row dft results
  cplx_vec_if #(.elem_t(row_cplx_t)) col_vec  ();  // transposed columns
  cplx_vec_if #(.elem_t(out_cplx_t)) col_spec ();  // column dft results

  // decode, serial samples into row vectors
  row_gather u_row_gather (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .sample_i       (sample_i),
    .sample_valid_i (sample_valid_i),
    .sample_ready_o (sample_ready_o),
    .row_o          (raw_row)
  );

  dft4_unit #(
    .in_t  (row_cplx_t),
    .out_t (row_cplx_t)
  ) u_row_dft (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .vec_i   (raw_row),
    .vec_o   (row_spec)
  );

  // two tiles in flight, ping-pong banks
  corner_turn_buffer u_corner_turn (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .row_i   (row_spec),
    .col_o   (col_vec)
  );

  dft4_unit #(
    .in_t  (row_cplx_t),
    .out_t (out_cplx_t)
  ) u_col_dft (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .vec_i   (col_vec),
    .vec_o   (col_spec)
  );

  out_serializer u_out_serializer (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .col_i       (col_spec),
    .out_re_o    (out_re_o),
    .out_im_o    (out_im_o),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .out_last_o  (out_last_o)
  );

endmodule

`default_nettype wire

// ==== tile_dft2d_tb_vectors.svh ====
`ifndef TILE_DFT2D_TB_VECTORS_SVH
`define TILE_DFT2D_TB_VECTORS_SVH

// table entries: 16 row-major samples, out_ready_i pattern per cycle, expected X[0][0]
localparam int NUM_VEC = 6;

int          tab_smp   [NUM_VEC][16];
logic [15:0] tab_stall [NUM_VEC];
int          tab_dc    [NUM_VEC];

task automatic load_vectors();
  for (int k = 0; k < 16; k++)
  begin
    tab_smp[0][k] = (k == 0) ? 1000 : 0;        // impulse, flat spectrum
    tab_smp[1][k] = 5;                          // constant, energy only in dc
    tab_smp[2][k] = -2048;                      // most negative input
    tab_smp[3][k] = 2047;                       // most positive input
    tab_smp[4][k] = ((k / 4 + k % 4) % 2 == 0) ? 2047 : -2048;  // checkerboard, peak at X[2][2]
  end
  tab_smp[5] = '{3, -7, 12, 0, -100, 55, 8, -1,
                 640, -640, 17, 2, -9, 31, 0, 1};
  tab_stall[0] = 16'hffff;  // no stalls
  tab_stall[1] = 16'haaaa;  // every other cycle
  tab_stall[2] = 16'h0f0f;  // bursts of four
  tab_stall[3] = 16'h3333;
  tab_stall[4] = 16'h5a5a;
  tab_stall[5] = 16'h7777;
  tab_dc[0] = 1000;
  tab_dc[1] = 80;           // 16 * 5
  tab_dc[2] = -32768;       // 16 * -2048, bottom of OUT_W
  tab_dc[3] = 32752;        // 16 * 2047
  tab_dc[4] = -8;
  tab_dc[5] = 12;
endtask

`endif

// ==== tile_dft2d_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module tile_dft2d_tb import dft2d_pkg::*;;

  `include "tile_dft2d_tb_vectors.svh"

  localparam int NUM_RAND    = 4;                         // random tiles after the table
  localparam int NUM_BP      = 3;                         // tiles pushed against held output
  localparam int NUM_STREAM  = NUM_VEC + NUM_RAND;
  localparam int NUM_TILES   = NUM_STREAM + NUM_BP;
  localparam int TIMEOUT_CYC = NUM_TILES * 64 + 200;
  localparam int STALL_LIMIT = 20;                        // input considered blocked
  localparam int NO_LIMIT    = 1 << 30;

  logic                    clk;
  logic                    rst_n_i;
  in_sample_t              sample_i;
  logic                    sample_valid_i;
  logic                    sample_ready_o;
  logic signed [OUT_W-1:0] out_re_o;
  logic signed [OUT_W-1:0] out_im_o;
  logic                    out_valid_o;
  logic                    out_ready_i;
  logic                    out_last_o;

  int          tile_smp  [NUM_TILES][TILE_SAMPLES];
  logic [15:0] stall_pat [NUM_TILES];
  int          exp_re [$];               // column-major expected values
  int          exp_im [$];
  bit          exp_last [$];
  int          seed;
  int          err_count;
  int          check_count;
  int          tiles_done;
  int          out_total;
  int          tile_err;
  int          cycle_cnt;
  int          drv_pos;                  // flat sample index into tile_smp
  int          drv_end;
  int          accepted;
  int          elem;
  int          cur_tile;
  int          e_re;
  int          e_im;
  bit          e_last;
  logic        hold_ready;
  bit          stalled;
  logic signed [OUT_W-1:0] held_re;
  logic signed [OUT_W-1:0] held_im;
  logic        held_last;

  tile_dft2d_top u_dut (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .sample_i       (sample_i),
    .sample_valid_i (sample_valid_i),
    .sample_ready_o (sample_ready_o),
    .out_re_o       (out_re_o),
    .out_im_o       (out_im_o),
    .out_valid_o    (out_valid_o),
    .out_ready_i    (out_ready_i),
    .out_last_o     (out_last_o)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;  // 20 ns period

  // X[u][v] straight from the kernel with W^k cycling 1 -j -1 +j
  task automatic push_expected(input int t);
    int re;
    int im;
    int x;
    for (int v = 0; v < TILE_N; v++)
    begin
      for (int u = 0; u < TILE_N; u++)
      begin
        re = 0;
        im = 0;
        for (int m = 0; m < TILE_N; m++)
        begin
          for (int n = 0; n < TILE_N; n++)
          begin
            x = tile_smp[t][m * TILE_N + n];
            case ((u * m + v * n) % 4)
              0: re += x;
              1: im -= x;
              2: re -= x;
              default: im += x;
            endcase
          end
        end
        exp_re.push_back(re);
        exp_im.push_back(im);
        exp_last.push_back(u == TILE_N - 1 && v == TILE_N - 1);
      end
    end
  endtask

  // offer samples drv_pos..drv_end-1 until stall_limit blocked cycles in a row
  task automatic drive_samples(input int stall_limit);
    int stall;
    stall = 0;
    sample_i       <= in_sample_t'(tile_smp[drv_pos / 16][drv_pos % 16]);
    sample_valid_i <= 1'b1;
    while (drv_pos < drv_end && stall < stall_limit)
    begin
      @(posedge clk);
      if (sample_ready_o)
      begin
        drv_pos++;  // transfer on this edge
        stall = 0;
        if (drv_pos < drv_end)
          sample_i <= in_sample_t'(tile_smp[drv_pos / 16][drv_pos % 16]);
        else
          sample_valid_i <= 1'b0;
      end
      else
        stall++;
    end
  endtask

  always @(posedge clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYC)
    begin
      $display("run timed out after %0d cycles with %0d of %0d tiles received",
               TIMEOUT_CYC, tiles_done, NUM_TILES);
      $display("sim failed");
      $finish;
    end
  end

  // output back-pressure follows the pattern of the tile being received
  always @(posedge clk)
  begin
    if (hold_ready)
      out_ready_i <= 1'b0;
    else if (tiles_done < NUM_TILES)
      out_ready_i <= stall_pat[tiles_done][cycle_cnt % 16];
    else
      out_ready_i <= 1'b1;
  end

  // monitor checks each output transfer against the queue
  always @(posedge clk)
  begin
    if (rst_n_i)
    begin
      if (stalled)
      begin
        assert (out_valid_o && out_re_o == held_re && out_im_o == held_im &&
                out_last_o == held_last)
        else
        begin
          $display("[FAIL] %0t: output changed while out_ready_i was low", $time);
          err_count++;
          tile_err++;
        end
      end
      stalled   = out_valid_o & ~out_ready_i;
      held_re   = out_re_o;
      held_im   = out_im_o;
      held_last = out_last_o;
      if (out_valid_o && out_ready_i)
      begin
        elem     = out_total % TILE_SAMPLES;
        cur_tile = out_total / TILE_SAMPLES;
        if (exp_re.size() == 0)
        begin
          $display("an output arrived at %0t with no tile outstanding", $time);
          err_count++;
        end
        else
        begin
          e_re   = exp_re.pop_front();
          e_im   = exp_im.pop_front();
          e_last = exp_last.pop_front();
          check_count++;
          assert (out_re_o == e_re && out_im_o == e_im && out_last_o == e_last)
          else
          begin
            $display("[FAIL] %0t: tile %0d out %0d got (%0d,%0d,%0b) want (%0d,%0d,%0b)",
                     $time, cur_tile, elem, out_re_o, out_im_o, out_last_o,
                     e_re, e_im, e_last);
            err_count++;
            tile_err++;
          end
          if (elem == 0 && cur_tile < NUM_VEC)
          begin
            assert (out_re_o == tab_dc[cur_tile] && out_im_o == 0)  // table dc term
            else
            begin
              $display("[FAIL] %0t: tile %0d dc got %0d want %0d",
                       $time, cur_tile, out_re_o, tab_dc[cur_tile]);
              err_count++;
              tile_err++;
            end
          end
        end
        out_total++;
        if (elem == TILE_SAMPLES - 1)
        begin
          $display("tile %0d: %s, %0d errors", cur_tile, tile_err == 0 ? "ok" : "bad", tile_err);
          tile_err = 0;
          tiles_done <= tiles_done + 1;
        end
      end
    end
  end

  initial
  begin
    seed           = 63050;
    rst_n_i        = 1'b0;
    sample_i       = '0;
    sample_valid_i = 1'b0;
    out_ready_i    = 1'b0;
    hold_ready     = 1'b0;
    err_count      = 0;
    check_count    = 0;
    tiles_done     = 0;
    out_total      = 0;
    tile_err       = 0;
    cycle_cnt      = 0;
    stalled        = 0;
    load_vectors();
    for (int t = 0; t < NUM_TILES; t++)
    begin
      for (int k = 0; k < TILE_SAMPLES; k++)
        tile_smp[t][k] = (t < NUM_VEC) ? tab_smp[t][k] : $random(seed) % 2048;
      if (t < NUM_VEC)
        stall_pat[t] = tab_stall[t];
      else if (t < NUM_STREAM)
        stall_pat[t] = 16'($random(seed)) | 16'h0001;  // never all stalled
      else
        stall_pat[t] = 16'hffff;
    end

    repeat (2) @(posedge clk);
    rst_n_i <= 1'b1;
    @(posedge clk);
    assert (out_valid_o == 1'b0 && sample_ready_o == 1'b1)
    else
    begin
      $display("[FAIL] %0t: reset state valid %0b ready %0b", $time, out_valid_o, sample_ready_o);
      err_count++;
    end
    $display("reset state: checked");

    // table then random tiles with no gaps between them
    for (int t = 0; t < NUM_STREAM; t++)
      push_expected(t);
    drv_pos = 0;
    drv_end = NUM_STREAM * TILE_SAMPLES;
    drive_samples(NO_LIMIT);
    while (tiles_done < NUM_STREAM)
      @(posedge clk);
    $display("stream: %0d tiles back to back done", NUM_STREAM);

    // with output held low the input must block before three tiles
    for (int t = NUM_STREAM; t < NUM_TILES; t++)
      push_expected(t);
    drv_end    = NUM_TILES * TILE_SAMPLES;
    hold_ready <= 1'b1;
    drive_samples(STALL_LIMIT);
    accepted = drv_pos - NUM_STREAM * TILE_SAMPLES;
    assert (accepted < NUM_BP * TILE_SAMPLES)
    else
    begin
      $display("[FAIL] %0t: %0d samples accepted with output held", $time, accepted);
      err_count++;
    end
    hold_ready <= 1'b0;
    drive_samples(NO_LIMIT);
    while (tiles_done < NUM_TILES)
      @(posedge clk);
    $display("backpressure: input blocked after %0d samples, all tiles drained", accepted);

    $display("tiles %0d, outputs %0d, checks %0d, errors %0d",
             tiles_done, out_total, check_count, err_count);
    if (err_count == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+.
dft2d_pkg.sv
cplx_vec_if.sv
row_gather.sv
dft4_unit.sv
corner_turn_buffer.sv
out_serializer.sv
tile_dft2d_top.sv
tile_dft2d_tb.sv

// ==== Bender.yml ====
package:
  name: tile_dft2d

sources:
  - dft2d_pkg.sv
  - cplx_vec_if.sv
  - row_gather.sv
  - dft4_unit.sv
  - corner_turn_buffer.sv
  - out_serializer.sv
  - tile_dft2d_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tile_dft2d_tb.sv
